/* verilog/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;

    // CSR numbers
    localparam csr_addr_t ADDR_CRMD   = 14'h000;
    localparam csr_addr_t ADDR_PRMD   = 14'h001;
    localparam csr_addr_t ADDR_ECFG   = 14'h004;
    localparam csr_addr_t ADDR_ESTAT  = 14'h005;
    localparam csr_addr_t ADDR_ERA    = 14'h006;
    localparam csr_addr_t ADDR_EENTRY = 14'h00c;
    localparam csr_addr_t ADDR_SAVE0  = 14'h030;
    localparam csr_addr_t ADDR_TID    = 14'h040;
    localparam csr_addr_t ADDR_TCFG   = 14'h041;
    localparam csr_addr_t ADDR_TVAL   = 14'h042;
    localparam csr_addr_t ADDR_TICLR  = 14'h044;

    // Field positions
    localparam int CRMD_PLV_LSB       = 0;
    localparam int CRMD_IE_BIT        = 2;
    localparam int CRMD_DA_BIT        = 3;
    localparam int CRMD_PG_BIT        = 4;
    localparam int CRMD_DATF_LSB      = 5;
    localparam int CRMD_DATM_LSB      = 7;
    localparam int PRMD_PPLV_LSB      = 0;
    localparam int PRMD_PIE_BIT       = 2;
    localparam int ESTAT_IS_LSB       = 0;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int EENTRY_VA_LSB      = 6;
    localparam int ECFG_LIE_LSB       = 0;
    localparam int TCFG_EN_BIT        = 0;
    localparam int TCFG_PERIODIC_BIT  = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int TICLR_CLR_BIT      = 0;

    // Interrupt vector layout
    localparam int IS_HW_LSB    = 2;
    localparam int IS_TIMER_BIT = 11;
    localparam int IS_IPI_BIT   = 12;

    // Bit 10 is reserved
    localparam int_vec_t  ECFG_LIE_MASK = 13'h1bff;
    localparam csr_word_t TIMER_IDLE    = 32'hffff_ffff;

    // Exception codes
    localparam ecode_t    ECODE_INT     = 6'h00;
    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam ecode_t    ECODE_SYS     = 6'h0b;
    localparam ecode_t    ECODE_BRK     = 6'h0c;
    localparam ecode_t    ECODE_INE     = 6'h0d;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    function automatic csr_word_t csr_merge(csr_word_t old_val, csr_word_t wmask,
                                            csr_word_t wvalue);
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

/* verilog/csr_write_if.sv */
`timescale 1ns/1ps

interface csr_write_if import csr_pkg::*; ();

    csr_addr_t csr_num;
    logic      csr_we;
    csr_word_t csr_wmask;
    csr_word_t csr_wvalue;

    modport source (
        output csr_num, csr_we, csr_wmask, csr_wvalue
    );

    modport unit (
        input csr_num, csr_we, csr_wmask, csr_wvalue
    );

endinterface

/* verilog/csr_trap_ctrl.sv */
`timescale 1ns/1ps

module csr_trap_ctrl import csr_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    csr_write_if.unit        wr,
    input  logic             wb_ex,
    input  logic             ertn_flush,
    input  ecode_t           wb_ecode,
    input  esubcode_t        wb_esubcode,
    input  csr_word_t        wb_pc,
    input  int_vec_t         estat_is,
    output logic             crmd_ie,
    output csr_word_t        ex_entry,
    output csr_word_t        rdata
);

    logic [1:0]  crmd_plv;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    csr_word_t   era_pc;
    logic [25:0] eentry_va;

    csr_word_t crmd_rv, prmd_rv, estat_rv, eentry_rv;
    csr_word_t crmd_wr, prmd_wr, eentry_wr;

    always_comb begin
        crmd_rv = '0;
        crmd_rv[CRMD_PLV_LSB +: 2]  = crmd_plv;
        crmd_rv[CRMD_IE_BIT]        = crmd_ie;
        crmd_rv[CRMD_DA_BIT]        = crmd_da;
        crmd_rv[CRMD_PG_BIT]        = crmd_pg;
        crmd_rv[CRMD_DATF_LSB +: 2] = crmd_datf;
        crmd_rv[CRMD_DATM_LSB +: 2] = crmd_datm;

        prmd_rv = '0;
        prmd_rv[PRMD_PPLV_LSB +: 2] = prmd_pplv;
        prmd_rv[PRMD_PIE_BIT]       = prmd_pie;

        estat_rv = '0;
        estat_rv[ESTAT_IS_LSB +: 13]      = estat_is;
        estat_rv[ESTAT_ECODE_LSB +: 6]    = estat_ecode;
        estat_rv[ESTAT_ESUBCODE_LSB +: 9] = estat_esubcode;

        // Entry is 64-byte aligned
        eentry_rv = '0;
        eentry_rv[EENTRY_VA_LSB +: 26] = eentry_va;
    end

    assign crmd_wr   = csr_merge(crmd_rv, wr.csr_wmask, wr.csr_wvalue);
    assign prmd_wr   = csr_merge(prmd_rv, wr.csr_wmask, wr.csr_wvalue);
    assign eentry_wr = csr_merge(eentry_rv, wr.csr_wmask, wr.csr_wvalue);

    // CRMD, with exception entry and return taking priority
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'b0;
            crmd_datm <= 2'b0;
        end else begin
            if (wb_ex) begin
                crmd_plv <= 2'b0;
                crmd_ie  <= 1'b0;
            end else if (ertn_flush) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (wr.csr_we && wr.csr_num == ADDR_CRMD) begin
                crmd_plv <= crmd_wr[CRMD_PLV_LSB +: 2];
                crmd_ie  <= crmd_wr[CRMD_IE_BIT];
            end
            if (wr.csr_we && wr.csr_num == ADDR_CRMD) begin
                crmd_da   <= crmd_wr[CRMD_DA_BIT];
                crmd_pg   <= crmd_wr[CRMD_PG_BIT];
                crmd_datf <= crmd_wr[CRMD_DATF_LSB +: 2];
                crmd_datm <= crmd_wr[CRMD_DATM_LSB +: 2];
            end
        end
    end

    // PRMD, exception codes and entry vector
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            eentry_va      <= '0;
        end else begin
            if (wb_ex) begin
                prmd_pplv      <= crmd_plv;
                prmd_pie       <= crmd_ie;
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end else if (wr.csr_we && wr.csr_num == ADDR_PRMD) begin
                prmd_pplv <= prmd_wr[PRMD_PPLV_LSB +: 2];
                prmd_pie  <= prmd_wr[PRMD_PIE_BIT];
            end
            if (wr.csr_we && wr.csr_num == ADDR_EENTRY) begin
                eentry_va <= eentry_wr[EENTRY_VA_LSB +: 26];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era_pc <= wb_pc;
        end else if (wr.csr_we && wr.csr_num == ADDR_ERA) begin
            era_pc <= csr_merge(era_pc, wr.csr_wmask, wr.csr_wvalue);
        end
    end

    assign ex_entry = eentry_rv;

    always_comb begin
        case (wr.csr_num)
            ADDR_CRMD:   rdata = crmd_rv;
            ADDR_PRMD:   rdata = prmd_rv;
            ADDR_ESTAT:  rdata = estat_rv;
            ADDR_ERA:    rdata = era_pc;
            ADDR_EENTRY: rdata = eentry_rv;
            default:     rdata = '0;
        endcase
    end

endmodule

/* verilog/csr_int_ctrl.sv */
`timescale 1ns/1ps

module csr_int_ctrl import csr_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    csr_write_if.unit   wr,
    input  logic [7:0]  hw_int,
    input  logic        ipi_int,
    input  logic        timer_zero,
    input  logic        crmd_ie,
    output int_vec_t    estat_is,
    output logic        has_int,
    output csr_word_t   rdata
);

    int_vec_t  ecfg_lie;
    csr_word_t ecfg_rv;
    csr_word_t ecfg_wr;
    logic      ticlr_clr;

    assign ecfg_rv = csr_word_t'(ecfg_lie) << ECFG_LIE_LSB;
    assign ecfg_wr = csr_merge(ecfg_rv, wr.csr_wmask, wr.csr_wvalue);

    assign ticlr_clr = wr.csr_we && wr.csr_num == ADDR_TICLR
                       && wr.csr_wmask[TICLR_CLR_BIT] && wr.csr_wvalue[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is <= '0;
            ecfg_lie <= '0;
        end else begin
            // Software interrupt bits
            if (wr.csr_we && wr.csr_num == ADDR_ESTAT) begin
                estat_is[ESTAT_IS_LSB +: 2] <=
                    (wr.csr_wmask[ESTAT_IS_LSB +: 2] & wr.csr_wvalue[ESTAT_IS_LSB +: 2])
                    | (~wr.csr_wmask[ESTAT_IS_LSB +: 2] & estat_is[ESTAT_IS_LSB +: 2]);
            end
            estat_is[IS_HW_LSB +: 8] <= hw_int;
            estat_is[10]             <= 1'b0;
            estat_is[IS_IPI_BIT]     <= ipi_int;

            // Timer set beats a clear in the same cycle
            if (timer_zero) begin
                estat_is[IS_TIMER_BIT] <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is[IS_TIMER_BIT] <= 1'b0;
            end

            if (wr.csr_we && wr.csr_num == ADDR_ECFG) begin
                ecfg_lie <= ecfg_wr[ECFG_LIE_LSB +: 13] & ECFG_LIE_MASK;
            end
        end
    end

    assign has_int = (|(estat_is & ecfg_lie)) && crmd_ie;

    // TICLR reads as zero
    assign rdata = (wr.csr_num == ADDR_ECFG) ? ecfg_rv : '0;

endmodule

/* verilog/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    csr_write_if.unit   wr,
    output logic        timer_zero,
    output csr_word_t   rdata
);

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_word_t   tcfg_rv;
    csr_word_t   tcfg_wr;
    csr_word_t   timer_cnt;
    logic        tcfg_we;

    always_comb begin
        tcfg_rv = '0;
        tcfg_rv[TCFG_EN_BIT]            = tcfg_en;
        tcfg_rv[TCFG_PERIODIC_BIT]      = tcfg_periodic;
        tcfg_rv[TCFG_INITVAL_LSB +: 30] = tcfg_initval;
    end

    assign tcfg_we = wr.csr_we && wr.csr_num == ADDR_TCFG;
    assign tcfg_wr = csr_merge(tcfg_rv, wr.csr_wmask, wr.csr_wvalue);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_wr[TCFG_EN_BIT];
            tcfg_periodic <= tcfg_wr[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_wr[TCFG_INITVAL_LSB +: 30];
        end
    end

    // Count is initval times 4, stops at all ones unless periodic
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= TIMER_IDLE;
        end else if (tcfg_we && tcfg_wr[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_wr[TCFG_INITVAL_LSB +: 30], 2'b00};
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    assign timer_zero = tcfg_en && timer_cnt == '0;

    always_comb begin
        case (wr.csr_num)
            ADDR_TCFG: rdata = tcfg_rv;
            ADDR_TVAL: rdata = timer_cnt;
            default:   rdata = '0;
        endcase
    end

endmodule

/* verilog/csr_save_regs.sv */
`timescale 1ns/1ps

module csr_save_regs import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic        clk,
    input  logic        resetn,
    csr_write_if.unit   wr,
    input  csr_word_t   coreid,
    output csr_word_t   rdata
);

    csr_word_t save_q  [NUM_SAVE];
    csr_word_t save_rd [NUM_SAVE];
    csr_word_t tid_q;

    for (genvar i = 0; i < NUM_SAVE; i++) begin : g_save
        localparam csr_addr_t SAVE_ADDR = ADDR_SAVE0 + csr_addr_t'(i);

        always_ff @(posedge clk) begin
            if (wr.csr_we && wr.csr_num == SAVE_ADDR) begin
                save_q[i] <= csr_merge(save_q[i], wr.csr_wmask, wr.csr_wvalue);
            end
        end

        assign save_rd[i] = (wr.csr_num == SAVE_ADDR) ? save_q[i] : '0;
    end

    // Core ID loaded while in reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tid_q <= coreid;
        end else if (wr.csr_we && wr.csr_num == ADDR_TID) begin
            tid_q <= csr_merge(tid_q, wr.csr_wmask, wr.csr_wvalue);
        end
    end

    always_comb begin
        rdata = (wr.csr_num == ADDR_TID) ? tid_q : '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            rdata = rdata | save_rd[i];
        end
    end

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/1ps

module csr_file import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic        clk,
    input  logic        resetn,
    input  csr_addr_t   csr_num,
    input  logic        csr_we,
    input  csr_word_t   csr_wmask,
    input  csr_word_t   csr_wvalue,
    input  logic        wb_ex,
    input  logic        ertn_flush,
    input  ecode_t      wb_ecode,
    input  esubcode_t   wb_esubcode,
    input  csr_word_t   wb_pc,
    input  logic [7:0]  hw_int,
    input  logic        ipi_int,
    input  csr_word_t   coreid,
    output csr_word_t   csr_rvalue,
    output csr_word_t   ex_entry,
    output logic        has_int
);

    csr_write_if wr_if ();

    assign wr_if.csr_num    = csr_num;
    assign wr_if.csr_we     = csr_we;
    assign wr_if.csr_wmask  = csr_wmask;
    assign wr_if.csr_wvalue = csr_wvalue;

    logic      crmd_ie;
    int_vec_t  estat_is;
    logic      timer_zero;
    csr_word_t trap_rdata, int_rdata, timer_rdata, save_rdata;

    csr_trap_ctrl trap_i (
        .clk(clk), .resetn(resetn), .wr(wr_if),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush),
        .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode), .wb_pc(wb_pc),
        .estat_is(estat_is), .crmd_ie(crmd_ie),
        .ex_entry(ex_entry), .rdata(trap_rdata)
    );

    csr_int_ctrl int_i (
        .clk(clk), .resetn(resetn), .wr(wr_if),
        .hw_int(hw_int), .ipi_int(ipi_int),
        .timer_zero(timer_zero), .crmd_ie(crmd_ie),
        .estat_is(estat_is), .has_int(has_int), .rdata(int_rdata)
    );

    csr_timer timer_i (
        .clk(clk), .resetn(resetn), .wr(wr_if),
        .timer_zero(timer_zero), .rdata(timer_rdata)
    );

    csr_save_regs #(.NUM_SAVE(NUM_SAVE)) save_i (
        .clk(clk), .resetn(resetn), .wr(wr_if),
        .coreid(coreid), .rdata(save_rdata)
    );

    // Units return zero outside their own addresses
    assign csr_rvalue = trap_rdata | int_rdata | timer_rdata | save_rdata;

endmodule

/* tests/csr_checker.sv */
`timescale 1ns/1ps

module csr_checker import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input logic       clk,
    input logic       resetn,
    input csr_addr_t  csr_num,
    input logic       csr_we,
    input csr_word_t  csr_wmask,
    input csr_word_t  csr_wvalue,
    input logic       wb_ex,
    input logic       ertn_flush,
    input ecode_t     wb_ecode,
    input esubcode_t  wb_esubcode,
    input csr_word_t  wb_pc,
    input logic [7:0] hw_int,
    input logic       ipi_int,
    input csr_word_t  coreid,
    input csr_word_t  csr_rvalue,
    input csr_word_t  ex_entry,
    input logic       has_int
);

    int unsigned check_count = 0;
    int unsigned error_count = 0;

    // Shadow registers
    csr_word_t crmd, prmd, era, eentry, tcfg, cnt, tid;
    ecode_t    ecode;
    esubcode_t esub;
    int_vec_t  is, lie;
    csr_word_t save [NUM_SAVE];

    // ERA and SAVE have no reset, so they are only compared once fully written
    logic era_known = 1'b0;
    logic save_known [NUM_SAVE];

    initial begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            save_known[i] <= 1'b0;
        end
    end

    function automatic csr_word_t masked(csr_word_t old_val, csr_word_t mask, csr_word_t val);
        return (old_val & ~mask) | (val & mask);
    endfunction

    function automatic logic writes_to(csr_addr_t addr);
        return csr_we && csr_num == addr;
    endfunction

    function automatic logic expected_int();
        return (|(is & lie)) && crmd[2];
    endfunction

    function automatic logic value_known(csr_addr_t addr);
        int idx;
        idx = int'(addr) - int'(ADDR_SAVE0);
        if (addr == ADDR_ERA) begin
            return era_known;
        end
        if (idx >= 0 && idx < NUM_SAVE) begin
            return save_known[idx];
        end
        return 1'b1;
    endfunction

    function automatic csr_word_t expected_read(csr_addr_t addr);
        csr_word_t v;
        int        idx;
        idx = int'(addr) - int'(ADDR_SAVE0);
        case (addr)
            ADDR_CRMD:   v = crmd;
            ADDR_PRMD:   v = prmd;
            ADDR_ESTAT:  v = {1'b0, esub, ecode, 3'b000, is};
            ADDR_ERA:    v = era;
            ADDR_EENTRY: v = eentry;
            ADDR_ECFG:   v = {19'b0, lie};
            ADDR_TID:    v = tid;
            ADDR_TCFG:   v = tcfg;
            ADDR_TVAL:   v = cnt;
            default:     v = '0;
        endcase
        if (idx >= 0 && idx < NUM_SAVE) begin
            v = save[idx];
        end
        return v;
    endfunction

    task automatic check_value(input string what, input csr_word_t got, input csr_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t: %s is 0x%08h, expected 0x%08h (csr_num 0x%03h)",
                     $time, what, got, exp, csr_num);
        end
    endtask

    always @(posedge clk) begin : model_update
        csr_word_t crmd_n;
        csr_word_t tcfg_n;
        csr_word_t lie_w;
        int_vec_t  is_n;

        if (!resetn) begin
            crmd   <= 32'h0000_0008;
            prmd   <= '0;
            ecode  <= '0;
            esub   <= '0;
            eentry <= '0;
            is     <= '0;
            lie    <= '0;
            tcfg   <= '0;
            cnt    <= 32'hffff_ffff;
            tid    <= coreid;
        end else begin
            // Exception beats return, return beats the write
            crmd_n = crmd;
            if (writes_to(ADDR_CRMD)) begin
                crmd_n = masked(crmd, csr_wmask, csr_wvalue) & 32'h0000_01ff;
            end
            if (wb_ex) begin
                crmd_n[2:0] = 3'b000;
            end else if (ertn_flush) begin
                crmd_n[2:0] = prmd[2:0];
            end
            crmd <= crmd_n;

            if (wb_ex) begin
                prmd  <= {29'b0, crmd[2:0]};
                ecode <= wb_ecode;
                esub  <= wb_esubcode;
            end else if (writes_to(ADDR_PRMD)) begin
                prmd <= masked(prmd, csr_wmask, csr_wvalue) & 32'h0000_0007;
            end

            if (writes_to(ADDR_EENTRY)) begin
                eentry <= masked(eentry, csr_wmask, csr_wvalue) & 32'hffff_ffc0;
            end
            if (writes_to(ADDR_ECFG)) begin
                lie_w = masked({19'b0, lie}, csr_wmask, csr_wvalue);
                lie <= lie_w[12:0] & 13'h1bff;
            end
            if (writes_to(ADDR_TID)) begin
                tid <= masked(tid, csr_wmask, csr_wvalue);
            end

            is_n = is;
            if (writes_to(ADDR_ESTAT)) begin
                is_n[1:0] = (is[1:0] & ~csr_wmask[1:0]) | (csr_wvalue[1:0] & csr_wmask[1:0]);
            end
            is_n[9:2] = hw_int;
            is_n[10]  = 1'b0;
            is_n[12]  = ipi_int;
            if (tcfg[0] && cnt == '0) begin
                is_n[11] = 1'b1;
            end else if (writes_to(ADDR_TICLR) && csr_wmask[0] && csr_wvalue[0]) begin
                is_n[11] = 1'b0;
            end
            is <= is_n;

            // Timer count is the initial value times 4
            tcfg_n = tcfg;
            if (writes_to(ADDR_TCFG)) begin
                tcfg_n = masked(tcfg, csr_wmask, csr_wvalue);
            end
            tcfg <= tcfg_n;
            if (writes_to(ADDR_TCFG) && tcfg_n[0]) begin
                cnt <= {tcfg_n[31:2], 2'b00};
            end else if (tcfg[0] && cnt != 32'hffff_ffff) begin
                if (cnt == '0 && tcfg[1]) begin
                    cnt <= {tcfg[31:2], 2'b00};
                end else begin
                    cnt <= cnt - 32'd1;
                end
            end
        end

        if (wb_ex) begin
            era       <= wb_pc;
            era_known <= 1'b1;
        end else if (writes_to(ADDR_ERA)) begin
            era <= masked(era, csr_wmask, csr_wvalue);
            if (csr_wmask == '1) begin
                era_known <= 1'b1;
            end
        end
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (csr_we && int'(csr_num) == int'(ADDR_SAVE0) + i) begin
                save[i] <= masked(save[i], csr_wmask, csr_wvalue);
                if (csr_wmask == '1) begin
                    save_known[i] <= 1'b1;
                end
            end
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (resetn) begin
            if (value_known(csr_num)) begin
                check_value("csr_rvalue", csr_rvalue, expected_read(csr_num));
            end
            check_value("ex_entry", ex_entry, eentry);
            check_value("has_int", {31'b0, has_int}, {31'b0, expected_int()});
        end
    end

endmodule

/* tests/tb_csr.sv */
`timescale 1ns/1ps

module tb_csr import csr_pkg::*;;

    localparam int NUM_SAVE = 4;

    logic       clk;
    logic       resetn;
    csr_addr_t  csr_num;
    logic       csr_we;
    csr_word_t  csr_wmask;
    csr_word_t  csr_wvalue;
    logic       wb_ex;
    logic       ertn_flush;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    csr_word_t  wb_pc;
    logic [7:0] hw_int;
    logic       ipi_int;
    csr_word_t  coreid;
    csr_word_t  csr_rvalue;
    csr_word_t  ex_entry;
    logic       has_int;

    integer seed = 38;
    int     timeouts = 0;

    csr_file #(.NUM_SAVE(NUM_SAVE)) dut_i (.*);

    csr_checker #(.NUM_SAVE(NUM_SAVE)) chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_word_t mask, input csr_word_t val);
        csr_num    = addr;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = val;
        tick();
        csr_we = 1'b0;
    endtask

    task automatic read_csr(input csr_addr_t addr);
        csr_num = addr;
        tick();
    endtask

    task automatic wait_for_bit(input csr_addr_t addr, input int bit_pos, input logic val,
                                input int limit, input string what);
        int n;
        csr_num = addr;
        n = 0;
        @(negedge clk);
        while (csr_rvalue[bit_pos] !== val && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (csr_rvalue[bit_pos] !== val) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
        tick();
    endtask

    task automatic wait_for_int(input logic val, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (has_int !== val && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (has_int !== val) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
        tick();
    endtask

    function automatic csr_addr_t pick_addr(int k);
        case (k)
            0, 1, 2, 3: return ADDR_SAVE0 + csr_addr_t'(k);
            4:          return ADDR_ERA;
            5:          return ADDR_EENTRY;
            6:          return ADDR_CRMD;
            7:          return ADDR_PRMD;
            default:    return ADDR_ECFG;
        endcase
    endfunction

    initial begin
        csr_addr_t a;
        csr_word_t m;
        csr_word_t v;

        resetn      = 1'b0;
        csr_num     = ADDR_CRMD;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        hw_int      = '0;
        ipi_int     = 1'b0;
        coreid      = 32'h0000_0003;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;

        read_csr(ADDR_CRMD);
        read_csr(ADDR_TVAL);
        read_csr(ADDR_TID);
        read_csr(ADDR_ECFG);
        read_csr(ADDR_ESTAT);

        // Fill the registers without reset first
        for (int i = 0; i < 5; i++) begin
            write_csr(pick_addr(i), '1, $random(seed));
        end
        for (int i = 0; i < 60; i++) begin
            a = pick_addr(int'($unsigned($random(seed)) % 9));
            m = $random(seed);
            v = $random(seed);
            write_csr(a, m, v);
            read_csr(a);
        end

        // Exception entry and return
        write_csr(ADDR_CRMD, 32'h7, 32'h7);
        write_csr(ADDR_EENTRY, '1, 32'h1c00_8000);
        wb_ex       = 1'b1;
        wb_ecode    = ECODE_SYS;
        wb_esubcode = 9'h005;
        wb_pc       = 32'h1c00_1234;
        tick();
        wb_ex = 1'b0;
        read_csr(ADDR_ERA);
        read_csr(ADDR_ESTAT);
        read_csr(ADDR_PRMD);
        read_csr(ADDR_CRMD);
        ertn_flush = 1'b1;
        tick();
        ertn_flush = 1'b0;
        read_csr(ADDR_CRMD);
        wb_ex    = 1'b1;
        wb_ecode = ECODE_BRK;
        wb_pc    = 32'h1c00_2000;
        write_csr(ADDR_CRMD, 32'h7, 32'h7);
        wb_ex = 1'b0;
        read_csr(ADDR_CRMD);
        read_csr(ADDR_PRMD);

        // One-shot timer, then periodic
        write_csr(ADDR_TCFG, '1, (32'd5 << 2) | 32'h1);
        repeat (8) read_csr(ADDR_TVAL);
        wait_for_bit(ADDR_ESTAT, 11, 1'b1, 40, "timer interrupt in one-shot mode");
        write_csr(ADDR_TICLR, 32'h1, 32'h1);
        read_csr(ADDR_ESTAT);
        repeat (4) read_csr(ADDR_TVAL);
        write_csr(ADDR_TCFG, '1, (32'd3 << 2) | 32'h3);
        wait_for_bit(ADDR_ESTAT, 11, 1'b1, 40, "first periodic timer interrupt");
        write_csr(ADDR_TICLR, 32'h1, 32'h1);
        wait_for_bit(ADDR_ESTAT, 11, 1'b1, 40, "timer interrupt after reload");
        write_csr(ADDR_TCFG, '1, 32'h0);
        write_csr(ADDR_TICLR, 32'h1, 32'h1);
        read_csr(ADDR_ESTAT);

        // Interrupt detection
        write_csr(ADDR_ECFG, '1, 32'h0000_1005);
        write_csr(ADDR_CRMD, 32'h4, 32'h4);
        hw_int = 8'h01;
        wait_for_int(1'b1, 10, "has_int from hw_int[0]");
        hw_int = 8'h00;
        wait_for_int(1'b0, 10, "has_int to drop after hw_int[0]");
        ipi_int = 1'b1;
        wait_for_int(1'b1, 10, "has_int from the IPI");
        write_csr(ADDR_CRMD, 32'h4, 32'h0);
        wait_for_int(1'b0, 10, "has_int to drop with IE clear");
        write_csr(ADDR_CRMD, 32'h4, 32'h4);
        wait_for_int(1'b1, 10, "has_int with IE set again");
        write_csr(ADDR_ECFG, 32'h1000, 32'h0);
        wait_for_int(1'b0, 10, "has_int to drop with LIE[12] clear");
        ipi_int = 1'b0;
        write_csr(ADDR_ESTAT, 32'h1, 32'h1);
        wait_for_int(1'b1, 10, "has_int from software bit 0");
        write_csr(ADDR_ESTAT, 32'h1, 32'h0);
        wait_for_int(1'b0, 10, "has_int to drop after software clear");
        repeat (2) tick();

        $display("checks=%0d errors=%0d timeouts=%0d",
                 chk_i.check_count, chk_i.error_count, timeouts);
        if (chk_i.error_count == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("Simulation time limit reached before the sequence finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sim.f */
verilog/csr_pkg.sv
verilog/csr_write_if.sv
verilog/csr_trap_ctrl.sv
verilog/csr_int_ctrl.sv
verilog/csr_timer.sv
verilog/csr_save_regs.sv
verilog/csr_file.sv
tests/csr_checker.sv
tests/tb_csr.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_csr
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
